// File: all.f
design/conv_pkg.sv
design/line_window.sv
design/kernel_mac.sv
design/frame_tracker.sv
design/conv_layer.sv
tests/conv_layer_tb.sv

// File: design/conv_layer.sv
`timescale 1ns/10ps

module conv_layer (
    input  logic                clk,
    input  logic                resetn,
    input  logic                in_valid,
    input  conv_pkg::pixel_t    pixel_c0,
    input  conv_pkg::pixel_t    pixel_c1,
    input  conv_pkg::pixel_t    pixel_c2,
    output logic                out_valid,
    output conv_pkg::acc_t      conv_out0,
    output conv_pkg::acc_t      conv_out1,
    output logic                done_img
);

    conv_pkg::window_t window;
    logic window_valid;

    line_window window_i (
        .clk            (clk),
        .resetn         (resetn),
        .in_valid       (in_valid),
        .pixel_c0       (pixel_c0),
        .pixel_c1       (pixel_c1),
        .pixel_c2       (pixel_c2),
        .window         (window),
        .window_valid   (window_valid)
    );

    kernel_mac #(.kernel_id(0)) mac0_i (
        .clk            (clk),
        .resetn         (resetn),
        .window_valid   (window_valid),
        .window         (window),
        .result         (conv_out0),
        .result_valid   (out_valid)
    );

    // same latency as mac0, so its valid is not needed
    kernel_mac #(.kernel_id(1)) mac1_i (
        .clk            (clk),
        .resetn         (resetn),
        .window_valid   (window_valid),
        .window         (window),
        .result         (conv_out1),
        .result_valid   ()
    );

    frame_tracker tracker_i (
        .clk            (clk),
        .resetn         (resetn),
        .out_valid      (out_valid),
        .done_img       (done_img)
    );

endmodule

// File: design/conv_pkg.sv
package conv_pkg;

    // image geometry
    localparam int img_width = 8;
    localparam int img_height = 6;
    localparam int win_size = 3;
    localparam int num_channel = 3;
    localparam int num_kernel = 2;
    localparam int num_tap = win_size * win_size;
    localparam int results_per_frame = (img_width - 2) * (img_height - 2);

    // counter widths
    localparam int col_w = $clog2(img_width);
    localparam int row_w = $clog2(img_height);
    localparam int count_w = $clog2(results_per_frame);

    // fixed-point word sizes
    localparam int pixel_w = 8;
    localparam int acc_w = 20;

    typedef logic signed [pixel_w-1:0] pixel_t;
    typedef logic signed [3:0] weight_t;
    typedef logic signed [acc_w-1:0] acc_t;

    // tap 0 is top-left (oldest), tap 8 is bottom-right (newest)
    typedef pixel_t [num_channel-1:0][num_tap-1:0] window_t;

    // indexed as [kernel][channel][tap]
    localparam weight_t kernel_weights [num_kernel][num_channel][num_tap] = '{
        '{
            '{4'sd1, 4'sd2, 4'sd1, 4'sd0, 4'sd0, 4'sd0, -4'sd1, -4'sd2, -4'sd1},
            '{4'sd1, 4'sd0, -4'sd1, 4'sd2, 4'sd0, -4'sd2, 4'sd1, 4'sd0, -4'sd1},
            '{4'sd3, 4'sd1, 4'sd0, 4'sd1, -4'sd4, -4'sd1, 4'sd0, -4'sd1, -4'sd3}
        },
        '{
            '{-4'sd7, 4'sd7, 4'sd0, 4'sd5, -4'sd3, 4'sd2, 4'sd1, -4'sd6, 4'sd4},
            '{4'sd2, -4'sd1, 4'sd3, -4'sd5, 4'sd6, -4'sd2, 4'sd0, 4'sd7, -4'sd7},
            '{-4'sd4, 4'sd0, 4'sd5, 4'sd1, -4'sd6, 4'sd3, 4'sd6, -4'sd1, 4'sd2}
        }
    };

    localparam acc_t kernel_bias [num_kernel] = '{20'sd37, -20'sd54};

endpackage

// File: design/frame_tracker.sv
`timescale 1ns/10ps

module frame_tracker (
    input  logic    clk,
    input  logic    resetn,
    input  logic    out_valid,
    output logic    done_img
);

    logic [conv_pkg::count_w-1:0] result_cnt;
    logic last_result;

    assign last_result = (result_cnt == conv_pkg::count_w'(conv_pkg::results_per_frame - 1));

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            result_cnt <= '0;
            done_img <= 1'b0;
        end
        else
        begin
            // one cycle pulse after the frame's final result
            done_img <= out_valid && last_result;
            if (out_valid)
            begin
                if (last_result)
                    result_cnt <= '0;
                else
                    result_cnt <= result_cnt + 1'b1;
            end
        end
    end

    done_single_cycle: assert property (@(posedge clk) disable iff (!resetn)
        done_img |=> !done_img);

endmodule

// File: design/kernel_mac.sv
`timescale 1ns/10ps

module kernel_mac #(
    parameter int kernel_id = 0
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                window_valid,
    input  conv_pkg::window_t   window,
    output conv_pkg::acc_t      result,
    output logic                result_valid
);

    conv_pkg::acc_t ch_next [conv_pkg::num_channel];
    conv_pkg::acc_t ch_sum [conv_pkg::num_channel];
    conv_pkg::acc_t total_next;
    int total_wide;
    logic s1_valid;

    // nine products per channel, sign extended before the multiply
    always_comb
    begin
        for (int c = 0; c < conv_pkg::num_channel; c++)
        begin
            ch_next[c] = '0;
            for (int t = 0; t < conv_pkg::num_tap; t++)
            begin
                ch_next[c] = ch_next[c]
                    + conv_pkg::acc_t'($signed(window[c][t]))
                    * conv_pkg::acc_t'(conv_pkg::kernel_weights[kernel_id][c][t]);
            end
        end
    end

    always_comb
    begin
        total_next = conv_pkg::kernel_bias[kernel_id];
        total_wide = int'(conv_pkg::kernel_bias[kernel_id]);
        for (int c = 0; c < conv_pkg::num_channel; c++)
        begin
            total_next = total_next + ch_sum[c];
            total_wide = total_wide + int'(ch_sum[c]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (window_valid)
            ch_sum <= ch_next;
        if (s1_valid)
            result <= total_next;
    end

    // valid bits follow the two data stages
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            s1_valid <= 1'b0;
            result_valid <= 1'b0;
        end
        else
        begin
            s1_valid <= window_valid;
            result_valid <= s1_valid;
        end
    end

    // the acc_t total must not wrap
    total_fits: assert property (@(posedge clk) disable iff (!resetn)
        s1_valid |-> int'(total_next) == total_wide);

endmodule

// File: design/line_window.sv
`timescale 1ns/10ps

module line_window (
    input  logic                clk,
    input  logic                resetn,
    input  logic                in_valid,
    input  conv_pkg::pixel_t    pixel_c0,
    input  conv_pkg::pixel_t    pixel_c1,
    input  conv_pkg::pixel_t    pixel_c2,
    output conv_pkg::window_t   window,
    output logic                window_valid
);

    conv_pkg::pixel_t pix_in [conv_pkg::num_channel];

    // two row delays per channel
    conv_pkg::pixel_t line_a [conv_pkg::num_channel][conv_pkg::img_width];
    conv_pkg::pixel_t line_b [conv_pkg::num_channel][conv_pkg::img_width];

    // 3x3 shift register per channel, [row][column]
    conv_pkg::pixel_t shift_q [conv_pkg::num_channel][conv_pkg::win_size][conv_pkg::win_size];
    conv_pkg::pixel_t row_in [conv_pkg::num_channel][conv_pkg::win_size];

    logic [conv_pkg::col_w-1:0] col_cnt;
    logic [conv_pkg::row_w-1:0] row_cnt;

    assign pix_in[0] = pixel_c0;
    assign pix_in[1] = pixel_c1;
    assign pix_in[2] = pixel_c2;

    // top row comes from two lines back, bottom row is the live pixel
    always_comb
    begin
        for (int c = 0; c < conv_pkg::num_channel; c++)
        begin
            row_in[c][0] = line_b[c][conv_pkg::img_width-1];
            row_in[c][1] = line_a[c][conv_pkg::img_width-1];
            row_in[c][2] = pix_in[c];
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            for (int c = 0; c < conv_pkg::num_channel; c++)
            begin
                line_a[c][0] <= pix_in[c];
                line_b[c][0] <= line_a[c][conv_pkg::img_width-1];
                for (int i = 1; i < conv_pkg::img_width; i++)
                begin
                    line_a[c][i] <= line_a[c][i-1];
                    line_b[c][i] <= line_b[c][i-1];
                end
                for (int r = 0; r < conv_pkg::win_size; r++)
                begin
                    shift_q[c][r][0] <= shift_q[c][r][1];
                    shift_q[c][r][1] <= shift_q[c][r][2];
                    shift_q[c][r][2] <= row_in[c][r];
                end
            end
        end
    end

    always_comb
    begin
        for (int c = 0; c < conv_pkg::num_channel; c++)
        begin
            for (int r = 0; r < conv_pkg::win_size; r++)
            begin
                for (int k = 0; k < conv_pkg::win_size; k++)
                begin
                    window[c][r*conv_pkg::win_size+k] = shift_q[c][r][k];
                end
            end
        end
    end

    // raster position of the next beat
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            col_cnt <= '0;
            row_cnt <= '0;
            window_valid <= 1'b0;
        end
        else
        begin
            window_valid <= in_valid && (col_cnt >= conv_pkg::win_size - 1)
                            && (row_cnt >= conv_pkg::win_size - 1);
            if (in_valid)
            begin
                if (col_cnt == conv_pkg::img_width - 1)
                begin
                    col_cnt <= '0;
                    if (row_cnt == conv_pkg::img_height - 1)
                        row_cnt <= '0;
                    else
                        row_cnt <= row_cnt + 1'b1;
                end
                else
                begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    // row count wraps at the frame end
    row_in_range: assert property (@(posedge clk) disable iff (!resetn)
        row_cnt <= conv_pkg::row_w'(conv_pkg::img_height - 1));

endmodule

// File: run.sh
#!/bin/sh
# build and run the conv_layer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module conv_layer_tb -f all.f -o conv_layer_sim

./obj_dir/conv_layer_sim | tee sim.log

if grep -q "^No errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: tests/conv_layer_tb.sv
`timescale 1ns/10ps

module conv_layer_tb;

    localparam int frame_beats = conv_pkg::img_width * conv_pkg::img_height;
    localparam int full_frames = 4;
    // four frames plus a half frame, gaps add about a third, rest is reset and drain margin
    localparam int cycle_limit = 4 * (full_frames + 1) * frame_beats + 40;

    logic clk;
    logic resetn;
    logic in_valid;
    conv_pkg::pixel_t pixel_c0;
    conv_pkg::pixel_t pixel_c1;
    conv_pkg::pixel_t pixel_c2;
    logic out_valid;
    conv_pkg::acc_t conv_out0;
    conv_pkg::acc_t conv_out1;
    logic done_img;

    logic [31:0] rng_state = 32'd93;
    int cycle_cnt = 0;
    int done_cycle = -1;
    int done_count = 0;
    int frame_results = 0;
    int mdl_row = 0;
    int mdl_col = 0;
    int img [conv_pkg::num_channel][conv_pkg::img_height][conv_pkg::img_width];

    // expected results in raster order
    int exp_sum0 [$];
    int exp_sum1 [$];
    int exp_cycle [$];
    bit exp_last [$];

    conv_layer dut_i (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .pixel_c0   (pixel_c0),
        .pixel_c1   (pixel_c1),
        .pixel_c2   (pixel_c2),
        .out_valid  (out_valid),
        .conv_out0  (conv_out0),
        .conv_out1  (conv_out1),
        .done_img   (done_img)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string name, int expected, int actual);
        if (expected != actual)
            report_failure($sformatf("[ERROR] %s: expected %0d, actual %0d",
                name, expected, actual));
    endtask

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
            report_failure($sformatf("timeout: run did not finish within %0d cycles",
                cycle_limit));
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int rand_pixel();
        logic [31:0] r;
        r = next_rand();
        return int'($signed(r[7:0]));
    endfunction

    // bias plus 27 products for the window ending at (row, col)
    function automatic int window_sum(int k, int row, int col);
        int sum;
        sum = int'(conv_pkg::kernel_bias[k]);
        for (int c = 0; c < conv_pkg::num_channel; c++)
            for (int r = 0; r < conv_pkg::win_size; r++)
                for (int x = 0; x < conv_pkg::win_size; x++)
                    sum += img[c][row - 2 + r][col - 2 + x]
                        * int'(conv_pkg::kernel_weights[k][c][r * conv_pkg::win_size + x]);
        return sum;
    endfunction

    // random idle cycles with junk data, then one beat
    task automatic drive_beat(int p0, int p1, int p2);
        while ((next_rand() & 32'd3) == 32'd0)
        begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            pixel_c0 = conv_pkg::pixel_t'(rand_pixel());
            pixel_c1 = conv_pkg::pixel_t'(rand_pixel());
            pixel_c2 = conv_pkg::pixel_t'(rand_pixel());
        end
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        pixel_c0 = conv_pkg::pixel_t'(p0);
        pixel_c1 = conv_pkg::pixel_t'(p1);
        pixel_c2 = conv_pkg::pixel_t'(p2);
        img[0][mdl_row][mdl_col] = p0;
        img[1][mdl_row][mdl_col] = p1;
        img[2][mdl_row][mdl_col] = p2;
        if (mdl_row >= 2 && mdl_col >= 2)
        begin
            exp_sum0.push_back(window_sum(0, mdl_row, mdl_col));
            exp_sum1.push_back(window_sum(1, mdl_row, mdl_col));
            exp_cycle.push_back(cycle_cnt);
            exp_last.push_back(mdl_row == conv_pkg::img_height - 1
                && mdl_col == conv_pkg::img_width - 1);
        end
        mdl_col = (mdl_col + 1) % conv_pkg::img_width;
        if (mdl_col == 0)
            mdl_row = (mdl_row + 1) % conv_pkg::img_height;
    endtask

    // mode 0 random, 1 all -128, 2 all 127
    task automatic drive_frame(int mode, int beats);
        int v;
        for (int i = 0; i < beats; i++)
        begin
            if (mode == 0)
                drive_beat(rand_pixel(), rand_pixel(), rand_pixel());
            else
            begin
                v = (mode == 1) ? -128 : 127;
                drive_beat(v, v, v);
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic apply_reset();
        resetn = 1'b0;
        in_valid = 1'b0;
        mdl_row = 0;
        mdl_col = 0;
        frame_results = 0;
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;
    endtask

    // until all results are out and the done pulses seen
    task automatic wait_drain(int dones);
        while (exp_sum0.size() != 0 || done_count < dones)
            @(posedge clk);
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic check_result();
        if (exp_sum0.size() == 0)
            report_failure("out_valid was high while no result was outstanding");
        else
        begin
            check_value("sum kernel 0", exp_sum0.pop_front(), int'(conv_out0));
            check_value("sum kernel 1", exp_sum1.pop_front(), int'(conv_out1));
            check_value("latency", exp_cycle.pop_front() + 3, cycle_cnt);
            if (exp_last.pop_front())
                done_cycle = cycle_cnt + 1;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk)
    begin
        if (!resetn)
        begin
            check_value("out_valid in reset", 0, int'(out_valid));
            check_value("done_img in reset", 0, int'(done_img));
        end
        else
        begin
            check_value("done_img", (cycle_cnt == done_cycle) ? 1 : 0, int'(done_img));
            if (done_img)
            begin
                done_count++;
                // out_valid beats between two done pulses
                check_value("results per frame", conv_pkg::results_per_frame,
                    frame_results);
                frame_results = 0;
            end
            if (out_valid)
            begin
                frame_results++;
                check_result();
            end
        end
    end

    initial
    begin
        in_valid = 1'b0;
        pixel_c0 = '0;
        pixel_c1 = '0;
        pixel_c2 = '0;
        apply_reset();
        // back to back: random, then extreme frames for sign and width
        drive_frame(0, frame_beats);
        drive_frame(1, frame_beats);
        drive_frame(2, frame_beats);
        wait_drain(3);
        // reset in the middle of an image, then a fresh frame
        drive_frame(0, frame_beats / 2);
        wait_drain(3);
        apply_reset();
        drive_frame(0, frame_beats);
        wait_drain(full_frames);
        $display("No errors");
        $finish;
    end

endmodule
